// File: src/qos_cfg_pkg.sv
package qos_cfg_pkg;

    // queue count and credit width
    localparam int QUEUE_NUM = 8;
    localparam int WEIGHT_W  = 4;

    // wrr pointer covers all queues
    localparam int PTR_W = 3;

    // wishbone slave widths
    localparam int WB_ADDR_W = 2;
    localparam int WB_DATA_W = 32;

    // REG_CTRL bit positions
    localparam int CTRL_MODE_BIT = 0;
    localparam int CTRL_EN_BIT   = 4;

    // register addresses as raw values
    localparam logic [WB_ADDR_W-1:0] ADDR_CTRL   = 2'd0;
    localparam logic [WB_ADDR_W-1:0] ADDR_WEIGHT = 2'd1;

endpackage

// File: src/qos_sched_pkg.sv
package qos_sched_pkg;

    import qos_cfg_pkg::*;

    typedef enum logic {
        SCHED_WRR = 1'b0,
        SCHED_SP  = 1'b1
    } sched_mode_e;

    typedef enum logic [WB_ADDR_W-1:0] {
        REG_CTRL   = ADDR_CTRL,
        REG_WEIGHT = ADDR_WEIGHT
    } reg_addr_e;

    typedef logic [QUEUE_NUM-1:0] queue_mask_t;
    typedef logic [WEIGHT_W-1:0]  weight_t;

    // queue i sits at bits 4i and up
    typedef weight_t [QUEUE_NUM-1:0] weight_vec_t;

    typedef struct packed {
        logic        enable;
        sched_mode_e mode;
        weight_vec_t weights;
    } qos_cfg_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [WB_DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic        vld;
        queue_mask_t grant;
    } sched_result_t;

endpackage

// File: src/qos_cfg_regs.sv
`timescale 1ns/1ps

module qos_cfg_regs
    import qos_cfg_pkg::*;
    import qos_sched_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  wb_req_t  i_wb,
    output wb_rsp_t  o_wb,
    output qos_cfg_t o_cfg,
    output logic     o_weight_load
);

    logic                 wb_start;
    logic                 ack_q;
    logic                 weight_load_q;
    logic [WB_DATA_W-1:0] ctrl_word;
    logic [WB_DATA_W-1:0] rd_word;
    logic [WB_DATA_W-1:0] rd_dat_q;
    reg_addr_e            addr;
    qos_cfg_t             cfg_q;

    // a new cycle is taken only while no ack is out
    assign wb_start = i_wb.cyc && i_wb.stb && !ack_q;
    assign addr     = reg_addr_e'(i_wb.adr);

    always_comb begin
        ctrl_word                = '0;
        ctrl_word[CTRL_MODE_BIT] = cfg_q.mode;
        ctrl_word[CTRL_EN_BIT]   = cfg_q.enable;
    end

    always_comb begin
        case (addr)
            REG_CTRL:   rd_word = ctrl_word;
            REG_WEIGHT: rd_word = cfg_q.weights;
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            ack_q         <= 1'b0;
            weight_load_q <= 1'b0;
            cfg_q.enable  <= 1'b0;
            cfg_q.mode    <= SCHED_WRR;
            cfg_q.weights <= '0;
        end else begin
            ack_q         <= wb_start;
            weight_load_q <= wb_start && i_wb.we && (addr == REG_WEIGHT);
            if (wb_start && i_wb.we) begin
                case (addr)
                    REG_CTRL: begin
                        cfg_q.mode   <= sched_mode_e'(i_wb.dat[CTRL_MODE_BIT]);
                        cfg_q.enable <= i_wb.dat[CTRL_EN_BIT];
                    end
                    REG_WEIGHT: cfg_q.weights <= i_wb.dat;
                    default: ;
                endcase
            end
        end
    end

    // sampled together with the ack
    always_ff @(posedge i_clk) begin
        if (wb_start) begin
            rd_dat_q <= rd_word;
        end
    end

    assign o_wb.ack      = ack_q;
    assign o_wb.dat      = rd_dat_q;
    assign o_cfg         = cfg_q;
    assign o_weight_load = weight_load_q;

endmodule

// File: src/qos_credit_bank.sv
`timescale 1ns/1ps

module qos_credit_bank
    import qos_cfg_pkg::*;
    import qos_sched_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  qos_cfg_t    i_cfg,
    input  logic        i_weight_load,
    input  logic        i_req,
    input  queue_mask_t i_take,
    output weight_vec_t o_credits
);

    weight_vec_t credit_q;
    weight_vec_t credit_eff;
    weight_vec_t credit_next;
    logic        credit_empty;

    assign credit_empty = (credit_q == '0);

    // empty bank reloads from the configured weights
    assign credit_eff = credit_empty ? i_cfg.weights : credit_q;

    // take is only set for a queue with a nonzero effective credit
    always_comb begin
        for (int q = 0; q < QUEUE_NUM; q++) begin
            credit_next[q] = credit_eff[q] - weight_t'(i_take[q]);
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            credit_q <= '0;
        end else if (i_weight_load) begin
            // forces a reload on the next request
            credit_q <= '0;
        end else if (i_cfg.mode == SCHED_SP) begin
            credit_q <= '0;
        end else if (i_req) begin
            credit_q <= credit_next;
        end
    end

    assign o_credits = credit_eff;

endmodule

// File: src/qos_arbiter.sv
`timescale 1ns/1ps

module qos_arbiter
    import qos_cfg_pkg::*;
    import qos_sched_pkg::*;
(
    input  logic          i_clk,
    input  logic          i_rst,
    input  qos_cfg_t      i_cfg,
    input  logic          i_req,
    input  queue_mask_t   i_ready,
    input  weight_vec_t   i_credits,
    output queue_mask_t   o_take,
    output sched_result_t o_result
);

    logic [PTR_W-1:0] ptr_q;
    queue_mask_t      eligible;
    queue_mask_t      wrr_grant;
    queue_mask_t      sp_grant;
    queue_mask_t      sel_grant;
    logic             wrr_active;
    sched_result_t    result_q;

    always_comb begin
        for (int q = 0; q < QUEUE_NUM; q++) begin
            eligible[q] = i_ready[q] && (i_credits[q] != '0);
        end
    end

    // start at queue N-1-ptr and walk down past queue 0 to queue 7
    always_comb begin
        logic [PTR_W-1:0] idx;
        logic             found;
        wrr_grant = '0;
        found     = 1'b0;
        for (int k = 0; k < QUEUE_NUM; k++) begin
            idx = PTR_W'(QUEUE_NUM - 1) - ptr_q - PTR_W'(k);
            if (!found && eligible[idx]) begin
                wrr_grant[idx] = 1'b1;
                found          = 1'b1;
            end
        end
    end

    // highest ready queue wins
    always_comb begin
        sp_grant = '0;
        for (int q = 0; q < QUEUE_NUM; q++) begin
            if (i_ready[q]) begin
                sp_grant    = '0;
                sp_grant[q] = 1'b1;
            end
        end
    end

    assign sel_grant  = (i_cfg.mode == SCHED_SP) ? sp_grant : wrr_grant;
    assign wrr_active = i_req && i_cfg.enable && (i_cfg.mode == SCHED_WRR);
    assign o_take     = wrr_active ? wrr_grant : '0;

    // pointer steps on every request in any mode and wraps from 7 to 0
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            ptr_q <= '0;
        end else if (i_req) begin
            ptr_q <= ptr_q + 1'b1;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            result_q <= '0;
        end else begin
            result_q.vld <= i_req;
            if (i_req) begin
                // disabled means the ready mask goes straight through
                result_q.grant <= i_cfg.enable ? sel_grant : i_ready;
            end
        end
    end

    assign o_result = result_q;

endmodule

// File: src/qos_sched_top.sv
`timescale 1ns/1ps

module qos_sched_top
    import qos_sched_pkg::*;
(
    input  logic          i_clk,
    input  logic          i_rst,
    input  wb_req_t       i_wb,
    output wb_rsp_t       o_wb,
    input  logic          i_req,
    input  queue_mask_t   i_ready,
    output sched_result_t o_result
);

    qos_cfg_t    cfg;
    logic        weight_load;
    queue_mask_t take;
    weight_vec_t credits;

    qos_cfg_regs u_cfg_regs (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_wb          (i_wb),
        .o_wb          (o_wb),
        .o_cfg         (cfg),
        .o_weight_load (weight_load)
    );

    // effective credits in, taken queue back out
    qos_credit_bank u_credit_bank (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_cfg         (cfg),
        .i_weight_load (weight_load),
        .i_req         (i_req),
        .i_take        (take),
        .o_credits     (credits)
    );

    qos_arbiter u_arbiter (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_cfg     (cfg),
        .i_req     (i_req),
        .i_ready   (i_ready),
        .i_credits (credits),
        .o_take    (take),
        .o_result  (o_result)
    );

endmodule

// File: test/tb_qos_sched_top.sv
`timescale 1ns/1ps

module tb_qos_sched_top
    import qos_cfg_pkg::*;
    import qos_sched_pkg::*;
();

    localparam int CLK_PERIOD    = 10;
    localparam int DRIVE_DELAY   = 1;
    localparam int RST_CYCLES    = 16;
    localparam int ACK_LIMIT     = 8;
    localparam int SP_REQS       = 24;
    localparam int WRR_REQS      = 64;
    localparam int BYPASS_REQS   = 16;
    localparam int RECFG_REQS    = 20;
    localparam int WB_OPS        = 32;
    localparam int TEST_CYCLES   = RST_CYCLES + SP_REQS + WRR_REQS + 2 * BYPASS_REQS
                                   + 4 * RECFG_REQS + 8 + WB_OPS * (ACK_LIMIT + 2);
    localparam int MARGIN_CYCLES = 100;
    localparam logic [WB_DATA_W-1:0] WRR_WEIGHTS = 32'h3241_2013;
    localparam logic [WB_DATA_W-1:0] NEW_WEIGHTS = 32'h1526_3741;

    logic          clk;
    logic          rst;
    wb_req_t       wb_req;
    wb_rsp_t       wb_rsp;
    logic          req;
    queue_mask_t   ready;
    sched_result_t result;

    integer      seed;
    int          errors;
    int          checks;
    int          model_weight [QUEUE_NUM];
    int          model_credit [QUEUE_NUM];
    int          model_ptr;
    logic        model_enable;
    sched_mode_e model_mode;

    qos_sched_top DUT (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_wb     (wb_req),
        .o_wb     (wb_rsp),
        .i_req    (req),
        .i_ready  (ready),
        .o_result (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("Errors found");
        $finish;
    end

    task automatic check_result(input sched_result_t got, input sched_result_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s vld %b grant %b, expected vld %b grant %b",
                     $time, what, got.vld, got.grant, exp.vld, exp.grant);
        end
    endtask

    task automatic check_wb_data(input wb_rsp_t got, input logic [WB_DATA_W-1:0] exp,
                                 input string what);
        checks++;
        if (got.dat !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s read %h, expected %h",
                     $time, what, got.dat, exp);
        end
    endtask

    function automatic logic [WB_DATA_W-1:0] ctrl_word(input logic en, input sched_mode_e mode);
        logic [WB_DATA_W-1:0] w;
        w                = '0;
        w[CTRL_MODE_BIT] = mode;
        w[CTRL_EN_BIT]   = en;
        return w;
    endfunction

    task automatic clear_credits();
        for (int i = 0; i < QUEUE_NUM; i++) begin
            model_credit[i] = 0;
        end
    endtask

    // one bus cycle, ack expected on the next edge and gone one edge later
    task automatic wb_access(input logic write, input logic [WB_ADDR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] dat, output wb_rsp_t rsp);
        int waited;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat: dat};
        waited = 0;
        while (!wb_rsp.ack && waited < ACK_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        rsp    = wb_rsp;
        wb_req = '0;
        if (!rsp.ack) begin
            errors++;
            $display("no Wishbone ack within %0d cycles at address %0d", ACK_LIMIT, adr);
        end else if (waited != 1) begin
            errors++;
            $display("Wishbone ack came %0d cycles after the request instead of 1", waited);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        if (wb_rsp.ack) begin
            errors++;
            $display("Wishbone ack stayed high for more than one cycle");
        end
    endtask

    task automatic cfg_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] dat);
        wb_rsp_t rsp;
        wb_access(1'b1, adr, dat, rsp);
        if (adr == REG_CTRL) begin
            model_mode   = sched_mode_e'(dat[CTRL_MODE_BIT]);
            model_enable = dat[CTRL_EN_BIT];
            if (model_mode == SCHED_SP) begin
                clear_credits();
            end
        end else if (adr == REG_WEIGHT) begin
            for (int i = 0; i < QUEUE_NUM; i++) begin
                model_weight[i] = int'(dat[WEIGHT_W*i +: WEIGHT_W]);
            end
            clear_credits();
        end
    endtask

    task automatic cfg_read(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] exp,
                            input string what);
        wb_rsp_t rsp;
        wb_access(1'b0, adr, '0, rsp);
        check_wb_data(rsp, exp, what);
    endtask

    // reference model: grant for one request, then credit and pointer update
    task automatic model_request(input queue_mask_t rdy, output queue_mask_t grant);
        int          eff [QUEUE_NUM];
        int          q;
        logic        empty;
        queue_mask_t wrr;
        queue_mask_t sp;
        empty = 1'b1;
        for (int i = 0; i < QUEUE_NUM; i++) begin
            if (model_credit[i] != 0) begin
                empty = 1'b0;
            end
        end
        for (int i = 0; i < QUEUE_NUM; i++) begin
            eff[i] = empty ? model_weight[i] : model_credit[i];
        end
        wrr = '0;
        for (int k = 0; k < QUEUE_NUM; k++) begin
            q = (2 * QUEUE_NUM - 1 - model_ptr - k) % QUEUE_NUM;
            if (wrr == '0 && rdy[q] && eff[q] != 0) begin
                wrr[q] = 1'b1;
            end
        end
        sp = '0;
        for (int i = QUEUE_NUM - 1; i >= 0; i--) begin
            if (sp == '0 && rdy[i]) begin
                sp[i] = 1'b1;
            end
        end
        if (!model_enable) begin
            grant = rdy;
        end else if (model_mode == SCHED_SP) begin
            grant = sp;
        end else begin
            grant = wrr;
        end
        if (model_mode == SCHED_WRR) begin
            for (int i = 0; i < QUEUE_NUM; i++) begin
                model_credit[i] = eff[i] - ((model_enable && wrr[i]) ? 1 : 0);
            end
        end else begin
            clear_credits();
        end
        model_ptr = (model_ptr + 1) % QUEUE_NUM;
    endtask

    // back to back requests, each result checked one cycle later
    task automatic run_stream(input int count, input string what);
        queue_mask_t   rdy;
        queue_mask_t   grant;
        sched_result_t exp;
        exp = '0;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (i > 0) begin
                check_result(result, exp, what);
            end
            rdy = queue_mask_t'($random(seed));
            // an empty mask now and then
            if (i % 9 == 4) begin
                rdy = '0;
            end
            model_request(rdy, grant);
            exp.vld   = 1'b1;
            exp.grant = grant;
            req       = 1'b1;
            ready     = rdy;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        check_result(result, exp, what);
        req   = 1'b0;
        ready = '0;
    endtask

    task automatic test_registers();
        check_result(result, '0, "result after reset");
        cfg_read(REG_CTRL, '0, "ctrl after reset");
        cfg_read(REG_WEIGHT, '0, "weights after reset");
        cfg_write(REG_CTRL, ctrl_word(1'b1, SCHED_SP));
        cfg_read(REG_CTRL, 32'h0000_0011, "ctrl readback");
        cfg_write(REG_WEIGHT, 32'hA5C3_0F96);
        cfg_read(REG_WEIGHT, 32'hA5C3_0F96, "weight readback");
        // only mode and enable bits are kept
        cfg_write(REG_CTRL, 32'hFFFF_FFEE);
        cfg_read(REG_CTRL, '0, "ctrl unused bits");
        cfg_write(2'd2, 32'hFFFF_FFFF);
        cfg_read(2'd2, '0, "unknown address 2");
        cfg_read(2'd3, '0, "unknown address 3");
        cfg_read(REG_WEIGHT, 32'hA5C3_0F96, "weights after unknown write");
    endtask

    task automatic test_sp();
        cfg_write(REG_CTRL, ctrl_word(1'b1, SCHED_SP));
        run_stream(SP_REQS, "sp grant");
    endtask

    task automatic test_wrr();
        cfg_write(REG_WEIGHT, WRR_WEIGHTS);
        cfg_write(REG_CTRL, ctrl_word(1'b1, SCHED_WRR));
        run_stream(WRR_REQS, "wrr grant");
    endtask

    task automatic test_bypass();
        cfg_write(REG_CTRL, ctrl_word(1'b0, SCHED_WRR));
        run_stream(BYPASS_REQS, "bypass in wrr mode");
        cfg_write(REG_CTRL, ctrl_word(1'b0, SCHED_SP));
        run_stream(BYPASS_REQS, "bypass in sp mode");
    endtask

    task automatic test_reconfig();
        cfg_write(REG_CTRL, ctrl_word(1'b1, SCHED_WRR));
        run_stream(RECFG_REQS, "wrr before switch");
        cfg_write(REG_CTRL, ctrl_word(1'b1, SCHED_SP));
        run_stream(RECFG_REQS, "sp after switch");
        cfg_write(REG_CTRL, ctrl_word(1'b1, SCHED_WRR));
        run_stream(RECFG_REQS, "wrr after switch back");
        cfg_write(REG_WEIGHT, NEW_WEIGHTS);
        run_stream(RECFG_REQS, "wrr with new weights");
    endtask

    initial begin
        seed         = 32'h8fba;
        errors       = 0;
        checks       = 0;
        model_ptr    = 0;
        model_enable = 1'b0;
        model_mode   = SCHED_WRR;
        for (int i = 0; i < QUEUE_NUM; i++) begin
            model_weight[i] = 0;
            model_credit[i] = 0;
        end
        rst    = 1'b1;
        wb_req = '0;
        req    = 1'b0;
        ready  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        test_registers();
        test_sp();
        test_wrr();
        test_bypass();
        test_reconfig();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: qos_sched_top.f
src/qos_cfg_pkg.sv
src/qos_sched_pkg.sv
src/qos_cfg_regs.sv
src/qos_credit_bank.sv
src/qos_arbiter.sv
src/qos_sched_top.sv
test/tb_qos_sched_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_qos_sched_top
FILELIST  ?= qos_sched_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= No errors

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass message
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
